/* verilog/matmul_macros.svh */
`ifndef MATMUL_MACROS_SVH
`define MATMUL_MACROS_SVH

// Bits per matrix element and per accumulated sum
`define MATMUL_DATA_WIDTH 32

// Rows and columns of each square matrix
`define MATMUL_SIZE 8

// Words held by one matrix memory
`define MATMUL_ELEMENTS 64

// Word address bits, row in the upper half and column in the lower half
`define MATMUL_ADDR_WIDTH 6

`endif

/* verilog/matmul_pkg.sv */
`include "matmul_macros.svh"

package matmul_pkg;

    // One matrix element, also used for running and finished sums
    typedef logic [`MATMUL_DATA_WIDTH-1:0] data_t;

    // Word address in a matrix memory, row * 8 + column
    typedef logic [`MATMUL_ADDR_WIDTH-1:0] addr_t;

    // Row, column or term index within one matrix
    typedef logic [$clog2(`MATMUL_SIZE)-1:0] index_t;

    // Engine control states
    typedef enum logic {
        IDLE,
        RUN
    } mac_state_t;

endpackage

/* verilog/matrix_ram.sv */
`include "matmul_macros.svh"

module matrix_ram
    import matmul_pkg::*;
(
    input  logic  clock,
    input  logic  wr_en,
    input  addr_t wr_addr,
    input  data_t wr_data,
    input  addr_t rd_addr,
    output data_t rd_data
);

    // Storage array, one word per matrix element
    data_t mem [`MATMUL_ELEMENTS];

    // Synchronous write port
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, data appears one cycle after the address
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* verilog/matmul.sv */
`include "matmul_macros.svh"

module matmul
    import matmul_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  start,
    input  data_t x_dout,
    input  data_t y_dout,
    output logic  done,
    output addr_t x_addr,
    output addr_t y_addr,
    output data_t z_din,
    output addr_t z_addr,
    output logic  z_wr_en
);

    localparam index_t LAST_INDEX = index_t'(`MATMUL_SIZE - 1);
    localparam addr_t  LAST_WORD  = addr_t'(`MATMUL_ELEMENTS - 1);

    mac_state_t state, next_state;
    logic done_c;

    // Fetch position: result row and column, and term within the dot product
    index_t row, row_c;
    index_t col, col_c;
    index_t term, term_c;
    logic fetching, fetching_c;

    // Next Z word to be written
    addr_t z_index, z_index_c;

    // Pipeline markers following the fetched addresses
    logic rd_valid, rd_valid_c;
    logic rd_last, rd_last_c;
    logic op_last, op_last_c;
    logic store_valid, store_valid_c;

    // Operand copies, running sum and finished sum waiting for its write
    data_t x_temp, x_temp_c;
    data_t y_temp, y_temp_c;
    data_t sum, sum_c;
    data_t store, store_c;
    data_t product;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state       <= IDLE;
            done        <= 1'b0;
            row         <= '0;
            col         <= '0;
            term        <= '0;
            fetching    <= 1'b0;
            z_index     <= '0;
            rd_valid    <= 1'b0;
            rd_last     <= 1'b0;
            op_last     <= 1'b0;
            store_valid <= 1'b0;
        end else begin
            state       <= next_state;
            done        <= done_c;
            row         <= row_c;
            col         <= col_c;
            term        <= term_c;
            fetching    <= fetching_c;
            z_index     <= z_index_c;
            rd_valid    <= rd_valid_c;
            rd_last     <= rd_last_c;
            op_last     <= op_last_c;
            store_valid <= store_valid_c;
        end
    end

    always_ff @(posedge clock) begin
        x_temp <= x_temp_c;
        y_temp <= y_temp_c;
        sum    <= sum_c;
        store  <= store_c;
    end

    // Low 32 bits of the product are the same for signed and unsigned operands
    assign product = x_temp * y_temp;

    always_comb begin
        x_addr  = '0;
        y_addr  = '0;
        z_addr  = '0;
        z_din   = '0;
        z_wr_en = 1'b0;

        next_state = state;
        done_c     = done;
        row_c      = row;
        col_c      = col;
        term_c     = term;
        fetching_c = fetching;
        z_index_c  = z_index;
        sum_c      = sum;
        store_c    = store;

        rd_valid_c    = 1'b0;
        rd_last_c     = 1'b0;
        op_last_c     = 1'b0;
        store_valid_c = 1'b0;

        // Memory outputs are only taken while they carry fetched operands
        x_temp_c = rd_valid ? x_dout : '0;
        y_temp_c = rd_valid ? y_dout : '0;

        case (state)
            IDLE: begin
                if (start) begin
                    next_state = RUN;
                    done_c     = 1'b0;
                    row_c      = '0;
                    col_c      = '0;
                    term_c     = '0;
                    fetching_c = 1'b1;
                    z_index_c  = '0;
                    sum_c      = '0;
                end
            end

            RUN: begin
                // Address phase, X walks along the row and Y down the column
                if (fetching) begin
                    x_addr = {row, term};
                    y_addr = {term, col};
                    term_c = term + 1'b1;
                    if (term == LAST_INDEX) begin
                        if (col == LAST_INDEX) begin
                            col_c = '0;
                            row_c = row + 1'b1;
                            if (row == LAST_INDEX) begin
                                fetching_c = 1'b0;
                            end
                        end else begin
                            col_c = col + 1'b1;
                        end
                    end
                end
                rd_valid_c = fetching;
                rd_last_c  = fetching && (term == LAST_INDEX);
                op_last_c  = rd_last;

                // Accumulate, handing the finished sum over to store
                if (op_last) begin
                    store_c       = sum + product;
                    sum_c         = '0;
                    store_valid_c = 1'b1;
                end else begin
                    sum_c = sum + product;
                end

                // Write back one finished dot product
                if (store_valid) begin
                    z_wr_en   = 1'b1;
                    z_addr    = z_index;
                    z_din     = store;
                    z_index_c = z_index + 1'b1;
                    if (z_index == LAST_WORD) begin
                        done_c     = 1'b1;
                        next_state = IDLE;
                    end
                end
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

/* verilog/matmul_top.sv */
module matmul_top
    import matmul_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  start,
    output logic  done,

    // Load port for matrix X
    input  logic  x_wr_en,
    input  addr_t x_wr_addr,
    input  data_t x_wr_data,

    // Load port for matrix Y
    input  logic  y_wr_en,
    input  addr_t y_wr_addr,
    input  data_t y_wr_data,

    // Readback port for matrix Z
    input  addr_t z_rd_addr,
    output data_t z_rd_data
);

    // Engine read side of X and Y
    addr_t x_addr;
    addr_t y_addr;
    data_t x_dout;
    data_t y_dout;

    // Engine write side of Z
    addr_t z_addr;
    data_t z_din;
    logic  z_wr_en;

    // Operand memory X, loaded from outside
    matrix_ram x_ram (
        .clock   (clock),
        .wr_en   (x_wr_en),
        .wr_addr (x_wr_addr),
        .wr_data (x_wr_data),
        .rd_addr (x_addr),
        .rd_data (x_dout)
    );

    // Operand memory Y
    matrix_ram y_ram (
        .clock   (clock),
        .wr_en   (y_wr_en),
        .wr_addr (y_wr_addr),
        .wr_data (y_wr_data),
        .rd_addr (y_addr),
        .rd_data (y_dout)
    );

    // Result memory, written by the engine and read from outside
    matrix_ram z_ram (
        .clock   (clock),
        .wr_en   (z_wr_en),
        .wr_addr (z_addr),
        .wr_data (z_din),
        .rd_addr (z_rd_addr),
        .rd_data (z_rd_data)
    );

    matmul matmul_inst (
        .clock   (clock),
        .reset   (reset),
        .start   (start),
        .x_dout  (x_dout),
        .y_dout  (y_dout),
        .done    (done),
        .x_addr  (x_addr),
        .y_addr  (y_addr),
        .z_din   (z_din),
        .z_addr  (z_addr),
        .z_wr_en (z_wr_en)
    );

endmodule

/* verification/matmul_properties.sv */
module matmul_properties
    import matmul_pkg::*;
(
    input logic       clock,
    input logic       reset,
    input logic       start,
    input logic       done,
    input logic       z_wr_en,
    input mac_state_t state
);

    // Set once the first start has been accepted after reset
    logic started;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            started <= 1'b0;
        end else if (start && state == IDLE) begin
            started <= 1'b1;
        end
    end

    no_write_in_idle: assert property (
        @(posedge clock) disable iff (reset) (state == IDLE) |-> !z_wr_en
    ) else $error("z_wr_en high while the engine is idle");

    no_write_when_done: assert property (
        @(posedge clock) disable iff (reset) done |-> !z_wr_en
    ) else $error("z_wr_en high while done is high");

    // An accepted start clears done on the next cycle
    done_falls_after_start: assert property (
        @(posedge clock) disable iff (reset) (state == IDLE && start) |=> !done
    ) else $error("done still high after an accepted start");

    quiet_until_first_start: assert property (
        @(posedge clock) disable iff (reset) !started |-> (!done && !z_wr_en)
    ) else $error("done or z_wr_en active before the first start");

endmodule

bind matmul matmul_properties matmul_properties_inst (
    .clock   (clock),
    .reset   (reset),
    .start   (start),
    .done    (done),
    .z_wr_en (z_wr_en),
    .state   (state)
);

/* verification/matmul_tb.sv */
`include "matmul_macros.svh"

module matmul_tb
    import matmul_pkg::*;
();

    localparam int SIZE = `MATMUL_SIZE;
    localparam int ELEMENTS = `MATMUL_ELEMENTS;
    localparam int DONE_TIMEOUT = 2000;
    localparam int COMPARE_TIMEOUT = 200;

    typedef data_t matrix_t [`MATMUL_ELEMENTS];

    logic  clock;
    logic  reset;
    logic  start;
    logic  done;
    logic  x_wr_en;
    addr_t x_wr_addr;
    data_t x_wr_data;
    logic  y_wr_en;
    addr_t y_wr_addr;
    data_t y_wr_data;
    addr_t z_rd_addr;
    data_t z_rd_data;

    matrix_t x_mat;
    matrix_t y_mat;
    matrix_t expected;

    integer seed;
    int     error_count;
    int     check_count;
    logic   compare_req;

    matmul_top matmul_top_inst (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .done      (done),
        .x_wr_en   (x_wr_en),
        .x_wr_addr (x_wr_addr),
        .x_wr_data (x_wr_data),
        .y_wr_en   (y_wr_en),
        .y_wr_addr (y_wr_addr),
        .y_wr_data (y_wr_data),
        .z_rd_addr (z_rd_addr),
        .z_rd_data (z_rd_data)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #10 clock = ~clock;
        end
    end

    // Z(r, c) is the sum over k of X(r, k) * Y(k, c), kept to 32 bits
    function automatic matrix_t reference_product(input matrix_t a, input matrix_t b);
        matrix_t result;
        data_t   acc;
        for (int r = 0; r < SIZE; r++) begin
            for (int c = 0; c < SIZE; c++) begin
                acc = '0;
                for (int k = 0; k < SIZE; k++) begin
                    acc = acc + a[r * SIZE + k] * b[k * SIZE + c];
                end
                result[r * SIZE + c] = acc;
            end
        end
        return result;
    endfunction

    task automatic check_value(input string name, input int index,
                               input data_t exp_value, input data_t act_value);
        check_count++;
        if (act_value !== exp_value) begin
            error_count++;
            $display("ERR at %0t: %s[%0d] expected %0d, got %0d", $time, name, index,
                     $signed(exp_value), $signed(act_value));
        end
    endtask

    task automatic load_matrices();
        for (int i = 0; i < ELEMENTS; i++) begin
            @(negedge clock);
            x_wr_en   = 1'b1;
            x_wr_addr = addr_t'(i);
            x_wr_data = x_mat[i];
            y_wr_en   = 1'b1;
            y_wr_addr = addr_t'(i);
            y_wr_data = y_mat[i];
        end
        @(negedge clock);
        x_wr_en = 1'b0;
        y_wr_en = 1'b0;
    endtask

    task automatic pulse_start();
        @(negedge clock);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (done !== 1'b1) begin
            error_count++;
            $display("Timeout: done never rose within %0d cycles", DONE_TIMEOUT);
        end
    endtask

    // Address on one falling edge, data sampled on the next
    task automatic read_back_z();
        for (int i = 0; i < ELEMENTS; i++) begin
            z_rd_addr = addr_t'(i);
            @(negedge clock);
            check_value("z_rd_data", i, expected[i], z_rd_data);
        end
        z_rd_addr = '0;
    endtask

    // Hands the readback to the compare process and waits until it is through
    task automatic run_compare();
        int cycles;
        cycles = 0;
        compare_req = 1'b1;
        while (compare_req && cycles < COMPARE_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (compare_req) begin
            error_count++;
            compare_req = 1'b0;
            $display("Timeout: Z readback did not finish within %0d cycles", COMPARE_TIMEOUT);
        end
    endtask

    // Compare process
    initial begin
        forever begin
            @(negedge clock);
            if (compare_req) begin
                read_back_z();
                compare_req = 1'b0;
            end
        end
    end

    initial begin
        seed        = 32'h1973;
        error_count = 0;
        check_count = 0;
        compare_req = 1'b0;
        reset       = 1'b1;
        start       = 1'b0;
        x_wr_en     = 1'b0;
        x_wr_addr   = '0;
        x_wr_data   = '0;
        y_wr_en     = 1'b0;
        y_wr_addr   = '0;
        y_wr_data   = '0;
        z_rd_addr   = '0;

        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // Idle after reset
        @(negedge clock);
        check_value("done", 0, '0, data_t'(done));

        // Small signed operands
        for (int i = 0; i < ELEMENTS; i++) begin
            x_mat[i] = data_t'($random(seed) % 100);
            y_mat[i] = data_t'($random(seed) % 100);
        end
        load_matrices();
        pulse_start();
        wait_for_done();
        expected = reference_product(x_mat, y_mat);
        run_compare();

        // Identity times Y gives Y back in row-major order
        for (int i = 0; i < ELEMENTS; i++) begin
            x_mat[i] = (i / SIZE == i % SIZE) ? 32'd1 : 32'd0;
            y_mat[i] = data_t'($random(seed));
        end
        load_matrices();
        pulse_start();
        wait_for_done();
        expected = y_mat;
        run_compare();

        // Operands near the 32-bit limits so that products and sums wrap
        for (int i = 0; i < ELEMENTS; i++) begin
            if (i % 2 == 0) begin
                x_mat[i] = 32'h7fff_0000 | (data_t'($random(seed)) & 32'h0000_ffff);
            end else begin
                x_mat[i] = 32'h8000_0000 | (data_t'($random(seed)) & 32'h0000_ffff);
            end
            if ((i / SIZE) % 2 == 0) begin
                y_mat[i] = 32'h8000_0000 | (data_t'($random(seed)) & 32'h0000_ffff);
            end else begin
                y_mat[i] = 32'h7fff_0000 | (data_t'($random(seed)) & 32'h0000_ffff);
            end
        end
        load_matrices();
        pulse_start();
        wait_for_done();
        expected = reference_product(x_mat, y_mat);
        run_compare();

        // Restart while done is still high from the previous run
        for (int i = 0; i < ELEMENTS; i++) begin
            x_mat[i] = data_t'($random(seed) % 1000);
            y_mat[i] = data_t'($random(seed) % 1000);
        end
        load_matrices();
        check_value("done", 0, 32'd1, data_t'(done));
        pulse_start();
        check_value("done", 0, '0, data_t'(done));
        wait_for_done();
        expected = reference_product(x_mat, y_mat);
        run_compare();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+verilog
verilog/matmul_pkg.sv
verilog/matrix_ram.sv
verilog/matmul.sv
verilog/matmul_top.sv
verification/matmul_properties.sv
verification/matmul_tb.sv

/* Bender.yml */
package:
  name: matmul

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/matmul_pkg.sv
      - verilog/matrix_ram.sv
      - verilog/matmul.sv
      - verilog/matmul_top.sv

  - target: simulation
    include_dirs:
      - verilog
    files:
      - verification/matmul_properties.sv
      - verification/matmul_tb.sv
